// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module tb_cpu

obj_dir/Vtb_cpu: tb.f hw/*.sv test/*.sv
	verilator --binary -j 0 -f tb.f --top-module tb_cpu -Mdir obj_dir

sim: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "^All tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
	parameter rv_pkg::word_t reset_vector = '0
) (
	input  logic clock,
	input  logic reset,
	output rv_pkg::word_t instr_addr,
	input  rv_pkg::word_t instr_data,
	output logic data_req,
	output logic data_write,
	output rv_pkg::word_t data_addr,
	output rv_pkg::word_t data_wdata,
	input  logic data_ack,
	input  rv_pkg::word_t data_rdata
);

	rv_pkg::word_t if_pc, if_instr, jump_target, branch_target;
	rv_pkg::word_t id_pc, id_rs1_data, id_rs2_data, id_imm;
	rv_pkg::word_t ex_result, ex_store_data, wb_data;
	rv_pkg::reg_addr_t dec_rs1, dec_rs2, id_rs1, id_rs2, id_rd, ex_rd, wb_rd;
	rv_pkg::alu_op_t id_alu_op;
	logic jump_taken, branch_taken;
	logic id_alu_src_imm, id_reg_write, id_mem_read, id_mem_write, id_branch, id_jump;
	logic ex_reg_write, ex_mem_read, ex_mem_write;
	logic wb_reg_write, mem_busy;
	logic stall_front, bubble_idex, flush_ifid, freeze_all;

	fetch_stage #(
		.reset_vector(reset_vector)
	) fetch_i (
		.stall(stall_front),
		.flush(flush_ifid),
		.*
	);

	decode_stage decode_i (
		.hold(freeze_all),
		.bubble(bubble_idex),
		.dec_mem_read_next(),
		.*
	);

	// a taken branch leaves execute as a bubble
	execute_stage execute_i (
		.hold(freeze_all),
		.flush(branch_taken),
		.ex_fwd_data(),
		.*
	);

	memory_stage memory_i (.*);

	hazard_unit hazard_i (.*);

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic clock,
	input  logic reset,
	input  logic hold,
	input  logic bubble,
	input  rv_pkg::word_t if_pc,
	input  rv_pkg::word_t if_instr,
	input  rv_pkg::reg_addr_t wb_rd,
	input  logic wb_reg_write,
	input  rv_pkg::word_t wb_data,
	output rv_pkg::reg_addr_t dec_rs1,
	output rv_pkg::reg_addr_t dec_rs2,
	output logic dec_mem_read_next,
	output logic jump_taken,
	output rv_pkg::word_t jump_target,
	output rv_pkg::word_t id_pc,
	output rv_pkg::word_t id_rs1_data,
	output rv_pkg::word_t id_rs2_data,
	output rv_pkg::reg_addr_t id_rs1,
	output rv_pkg::reg_addr_t id_rs2,
	output rv_pkg::reg_addr_t id_rd,
	output rv_pkg::word_t id_imm,
	output rv_pkg::alu_op_t id_alu_op,
	output logic id_alu_src_imm,
	output logic id_reg_write,
	output logic id_mem_read,
	output logic id_mem_write,
	output logic id_branch,
	output logic id_jump
);

	rv_pkg::opcode_t opcode;
	rv_pkg::reg_addr_t rs1, rs2;
	rv_pkg::word_t rs1_data, rs2_data;
	rv_pkg::word_t imm_i, imm_s, imm_b, imm_j, imm;
	rv_pkg::alu_op_t alu_op;
	logic alu_src_imm, reg_write, mem_read, mem_write, branch, jump;
	logic use_rs1, use_rs2;

	register_file regs_i (.*);

	assign opcode = rv_pkg::opcode_t'(if_instr[6:0]);
	assign rs1 = if_instr[19:15];
	assign rs2 = if_instr[24:20];

	assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
		if_instr[11:8], 1'b0};
	assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
		if_instr[30:21], 1'b0};

	always_comb begin
		alu_op = rv_pkg::alu_add;
		alu_src_imm = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		imm = imm_i;
		case (opcode)
			rv_pkg::op_reg: begin
				reg_write = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				case (if_instr[14:12])
					3'b000: alu_op = if_instr[30] ? rv_pkg::alu_sub : rv_pkg::alu_add;
					3'b010: alu_op = rv_pkg::alu_slt;
					3'b100: alu_op = rv_pkg::alu_xor;
					3'b110: alu_op = rv_pkg::alu_or;
					3'b111: alu_op = rv_pkg::alu_and;
					default: alu_op = rv_pkg::alu_add;
				endcase
			end
			rv_pkg::op_imm: begin
				alu_src_imm = 1'b1;
				reg_write = 1'b1;
				use_rs1 = 1'b1;
			end
			rv_pkg::op_load: begin
				alu_src_imm = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
				use_rs1 = 1'b1;
			end
			rv_pkg::op_store: begin
				alu_src_imm = 1'b1;
				mem_write = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				imm = imm_s;
			end
			rv_pkg::op_branch: begin
				branch = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				imm = imm_b;
			end
			rv_pkg::op_jal: begin
				// link value is pc + 4, computed by the alu
				jump = 1'b1;
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				imm = 32'd4;
			end
			default: ;
		endcase
	end

	assign jump_taken = jump;
	assign jump_target = if_pc + imm_j;

	// only real source registers count for the load-use check
	assign dec_rs1 = use_rs1 ? rs1 : '0;
	assign dec_rs2 = use_rs2 ? rs2 : '0;
	assign dec_mem_read_next = mem_read;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_pc <= '0;
			id_rs1_data <= '0;
			id_rs2_data <= '0;
			id_rs1 <= '0;
			id_rs2 <= '0;
			id_rd <= '0;
			id_imm <= '0;
			id_alu_op <= rv_pkg::alu_add;
			id_alu_src_imm <= 1'b0;
			id_reg_write <= 1'b0;
			id_mem_read <= 1'b0;
			id_mem_write <= 1'b0;
			id_branch <= 1'b0;
			id_jump <= 1'b0;
		end else if (hold) begin
			// frozen entry still picks up writebacks to its sources
			if (wb_reg_write && wb_rd != '0 && wb_rd == id_rs1) begin
				id_rs1_data <= wb_data;
			end
			if (wb_reg_write && wb_rd != '0 && wb_rd == id_rs2) begin
				id_rs2_data <= wb_data;
			end
		end else begin
			id_pc <= bubble ? '0 : if_pc;
			id_rs1_data <= bubble ? '0 : rs1_data;
			id_rs2_data <= bubble ? '0 : rs2_data;
			id_rs1 <= bubble ? '0 : rs1;
			id_rs2 <= bubble ? '0 : rs2;
			id_rd <= bubble ? '0 : if_instr[11:7];
			id_imm <= bubble ? '0 : imm;
			id_alu_op <= bubble ? rv_pkg::alu_add : alu_op;
			id_alu_src_imm <= alu_src_imm && !bubble;
			id_reg_write <= reg_write && !bubble;
			id_mem_read <= mem_read && !bubble;
			id_mem_write <= mem_write && !bubble;
			id_branch <= branch && !bubble;
			id_jump <= jump && !bubble;
		end
	end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic clock,
	input  logic reset,
	input  logic hold,
	input  logic flush,
	input  rv_pkg::word_t id_pc,
	input  rv_pkg::word_t id_rs1_data,
	input  rv_pkg::word_t id_rs2_data,
	input  rv_pkg::reg_addr_t id_rs1,
	input  rv_pkg::reg_addr_t id_rs2,
	input  rv_pkg::reg_addr_t id_rd,
	input  rv_pkg::word_t id_imm,
	input  rv_pkg::alu_op_t id_alu_op,
	input  logic id_alu_src_imm,
	input  logic id_reg_write,
	input  logic id_mem_read,
	input  logic id_mem_write,
	input  logic id_branch,
	input  logic id_jump,
	output rv_pkg::word_t ex_fwd_data,
	input  rv_pkg::reg_addr_t wb_rd,
	input  logic wb_reg_write,
	input  rv_pkg::word_t wb_data,
	output logic branch_taken,
	output rv_pkg::word_t branch_target,
	output rv_pkg::word_t ex_result,
	output rv_pkg::word_t ex_store_data,
	output rv_pkg::reg_addr_t ex_rd,
	output logic ex_reg_write,
	output logic ex_mem_read,
	output logic ex_mem_write
);

	rv_pkg::word_t opnd_a, opnd_b;
	rv_pkg::word_t alu_a, alu_b, alu_out;
	logic ex_fwd_ok, wb_fwd_ok;

	// a load in memory has no data yet, load-use stall covers it
	assign ex_fwd_ok = ex_reg_write && !ex_mem_read && ex_rd != '0;
	assign wb_fwd_ok = wb_reg_write && wb_rd != '0;
	assign ex_fwd_data = ex_result;

	always_comb begin
		if (ex_fwd_ok && ex_rd == id_rs1) begin
			opnd_a = ex_result;
		end else if (wb_fwd_ok && wb_rd == id_rs1) begin
			opnd_a = wb_data;
		end else begin
			opnd_a = id_rs1_data;
		end
		if (ex_fwd_ok && ex_rd == id_rs2) begin
			opnd_b = ex_result;
		end else if (wb_fwd_ok && wb_rd == id_rs2) begin
			opnd_b = wb_data;
		end else begin
			opnd_b = id_rs2_data;
		end
	end

	// jal goes through as pc + 4
	assign alu_a = id_jump ? id_pc : opnd_a;
	assign alu_b = id_alu_src_imm ? id_imm : opnd_b;

	always_comb begin
		case (id_alu_op)
			rv_pkg::alu_sub: alu_out = alu_a - alu_b;
			rv_pkg::alu_and: alu_out = alu_a & alu_b;
			rv_pkg::alu_or: alu_out = alu_a | alu_b;
			rv_pkg::alu_xor: alu_out = alu_a ^ alu_b;
			rv_pkg::alu_slt: alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
			default: alu_out = alu_a + alu_b;
		endcase
	end

	assign branch_taken = id_branch && (opnd_a == opnd_b);
	assign branch_target = id_pc + id_imm;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_result <= '0;
			ex_store_data <= '0;
			ex_rd <= '0;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
		end else if (!hold) begin
			ex_result <= alu_out;
			ex_store_data <= opnd_b;
			ex_rd <= flush ? '0 : id_rd;
			ex_reg_write <= id_reg_write && !flush;
			ex_mem_read <= id_mem_read && !flush;
			ex_mem_write <= id_mem_write && !flush;
		end
	end

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
	parameter rv_pkg::word_t reset_vector = '0
) (
	input  logic clock,
	input  logic reset,
	input  logic stall,
	input  logic flush,
	input  logic jump_taken,
	input  logic branch_taken,
	input  rv_pkg::word_t jump_target,
	input  rv_pkg::word_t branch_target,
	output rv_pkg::word_t instr_addr,
	input  rv_pkg::word_t instr_data,
	output rv_pkg::word_t if_pc,
	output rv_pkg::word_t if_instr
);

	rv_pkg::word_t pc;
	rv_pkg::word_t next_pc;

	assign instr_addr = pc;

	// branch in execute is older than a jump in decode
	always_comb begin
		if (branch_taken) begin
			next_pc = branch_target;
		end else if (jump_taken) begin
			next_pc = jump_target;
		end else begin
			next_pc = pc + 32'd4;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_vector;
			if_pc <= '0;
			if_instr <= rv_pkg::nop_instr;
		end else if (!stall) begin
			pc <= next_pc;
			if_pc <= pc;
			if_instr <= flush ? rv_pkg::nop_instr : instr_data;
		end
	end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input  rv_pkg::reg_addr_t dec_rs1,
	input  rv_pkg::reg_addr_t dec_rs2,
	input  rv_pkg::reg_addr_t id_rd,
	input  logic id_mem_read,
	input  logic jump_taken,
	input  logic branch_taken,
	input  logic mem_busy,
	output logic stall_front,
	output logic bubble_idex,
	output logic flush_ifid,
	output logic freeze_all
);

	logic load_use;

	// load in execute feeding the instruction in decode
	assign load_use = id_mem_read && id_rd != '0 &&
		(id_rd == dec_rs1 || id_rd == dec_rs2);

	assign stall_front = load_use || mem_busy;
	assign bubble_idex = load_use || branch_taken;
	assign flush_ifid = jump_taken || branch_taken;
	assign freeze_all = mem_busy;

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
	input  logic clock,
	input  logic reset,
	input  rv_pkg::word_t ex_result,
	input  rv_pkg::word_t ex_store_data,
	input  rv_pkg::reg_addr_t ex_rd,
	input  logic ex_reg_write,
	input  logic ex_mem_read,
	input  logic ex_mem_write,
	output logic data_req,
	output logic data_write,
	output rv_pkg::word_t data_addr,
	output rv_pkg::word_t data_wdata,
	input  logic data_ack,
	input  rv_pkg::word_t data_rdata,
	output logic mem_busy,
	output rv_pkg::reg_addr_t wb_rd,
	output logic wb_reg_write,
	output rv_pkg::word_t wb_data
);

	rv_pkg::mem_state_t state;
	rv_pkg::word_t load_data;
	logic access;

	assign access = ex_mem_read || ex_mem_write;

	// request fields come straight from the frozen ex/mem entry
	assign data_req = (state == rv_pkg::mem_idle && access) || state == rv_pkg::mem_wait_ack;
	assign data_write = ex_mem_write;
	assign data_addr = ex_result;
	assign data_wdata = ex_store_data;

	// done once ack has dropped after req was lowered
	assign mem_busy = data_req || (state == rv_pkg::mem_wait_release && data_ack);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= rv_pkg::mem_idle;
		end else begin
			case (state)
				rv_pkg::mem_idle: begin
					if (access) begin
						state <= rv_pkg::mem_wait_ack;
					end
				end
				rv_pkg::mem_wait_ack: begin
					if (data_ack) begin
						state <= rv_pkg::mem_wait_release;
					end
				end
				rv_pkg::mem_wait_release: begin
					if (!data_ack) begin
						state <= rv_pkg::mem_idle;
					end
				end
				default: state <= rv_pkg::mem_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == rv_pkg::mem_wait_ack && data_ack) begin
			load_data <= data_rdata;
		end
	end

	// bubble into writeback while the access is in progress
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_rd <= '0;
			wb_reg_write <= 1'b0;
			wb_data <= '0;
		end else if (mem_busy) begin
			wb_rd <= '0;
			wb_reg_write <= 1'b0;
		end else begin
			wb_rd <= ex_rd;
			wb_reg_write <= ex_reg_write;
			wb_data <= ex_mem_read ? load_data : ex_result;
		end
	end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic clock,
	input  logic reset,
	input  rv_pkg::reg_addr_t rs1,
	input  rv_pkg::reg_addr_t rs2,
	output rv_pkg::word_t rs1_data,
	output rv_pkg::word_t rs2_data,
	input  rv_pkg::reg_addr_t wb_rd,
	input  logic wb_reg_write,
	input  rv_pkg::word_t wb_data
);

	rv_pkg::word_t regs [32];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_reg_write && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// x0 reads zero, same-cycle write passes straight through
	assign rs1_data = (rs1 == '0) ? '0 :
		(wb_reg_write && wb_rd == rs1) ? wb_data : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 :
		(wb_reg_write && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

	// four-phase data handshake
	typedef enum logic [1:0] {
		mem_idle,
		mem_wait_ack,
		mem_wait_release
	} mem_state_t;

	// addi x0,x0,0
	localparam word_t nop_instr = 32'h0000_0013;

endpackage

// ==== tb.f ====
hw/rv_pkg.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/hazard_unit.sv
hw/cpu_core.sv
test/tb_cpu.sv

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

	localparam int num_tests = 6;
	localparam int cycle_limit = 400 * num_tests;
	localparam rv_pkg::word_t done_addr = 32'h0000_03fc;
	localparam rv_pkg::word_t marker = 32'h0000_05a5;
	localparam int alu_a = 1234;
	localparam int alu_b = -567;
	localparam int alu_base = 'h100;
	localparam int chain_base = 'h140;
	localparam int load_base = 'h200;
	localparam int flow_base = 'h300;

	logic clock = 1'b0;
	logic reset;
	rv_pkg::word_t instr_addr;
	rv_pkg::word_t instr_data;
	logic data_req;
	logic data_write;
	logic data_ack;
	rv_pkg::word_t data_addr;
	rv_pkg::word_t data_wdata;
	rv_pkg::word_t data_rdata;

	rv_pkg::word_t imem [256];
	rv_pkg::word_t dmem [256];
	logic [7:0] load_slot;
	int errors;
	int checks;
	int cycle_count = 0;
	int marker_writes;
	logic backpressure;
	logic done_seen;
	logic prev_req = 1'b0;
	logic req_during_ack = 1'b0;
	rv_pkg::word_t lfsr_state;

	cpu_core #(
		.reset_vector(32'h0)
	) dut_i (
		.clock(clock),
		.reset(reset),
		.instr_addr(instr_addr),
		.instr_data(instr_data),
		.data_req(data_req),
		.data_write(data_write),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_ack(data_ack),
		.data_rdata(data_rdata)
	);

	always #50 clock = ~clock;

	// instruction fetch answers in the same cycle
	assign instr_data = imem[instr_addr[9:2]];

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("ERROR: timeout, the run went past %0d cycles", cycle_limit);
			$display("Some tests failed");
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$finish;
		end
	end

	// a new request has to wait until the previous ack fell
	always @(negedge clock) begin
		if (reset && data_req && !prev_req && data_ack) begin
			$display("ERROR t=%0t: data_req rose while data_ack was still high", $time);
			req_during_ack = 1'b1;
		end
		prev_req = data_req;
	end

	function automatic rv_pkg::word_t lfsr_step(input rv_pkg::word_t s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output rv_pkg::word_t value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// data memory side of the four-phase handshake
	initial begin : data_memory
		int delay;
		rv_pkg::word_t addr;
		rv_pkg::word_t wdata;
		rv_pkg::word_t value;
		logic write;
		data_ack = 1'b0;
		data_rdata = '0;
		forever begin
			@(negedge clock);
			if (reset && data_req && !data_ack) begin
				addr = data_addr;
				wdata = data_wdata;
				write = data_write;
				delay = 0;
				if (backpressure) begin
					take_bits(3, value);
					delay = int'(value);
				end
				repeat (delay) @(posedge clock);
				@(posedge clock);
				#1;
				if (write) begin
					dmem[addr[9:2]] = wdata;
					if (wdata == marker) begin
						marker_writes++;
					end
					if (addr == done_addr) begin
						done_seen = 1'b1;
					end
				end else begin
					data_rdata = dmem[addr[9:2]];
				end
				data_ack = 1'b1;
				do begin
					@(negedge clock);
				end while (data_req);
				@(posedge clock);
				#1;
				data_ack = 1'b0;
				data_rdata = '0;
			end
		end
	end

	task automatic check_word(input string name, input rv_pkg::word_t actual,
		input rv_pkg::word_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL t=%0t %s: got %b, expected %b", $time, name, actual, expected);
		end
	endtask

	function automatic rv_pkg::word_t read_data(input rv_pkg::word_t addr);
		return dmem[addr[9:2]];
	endfunction

	function automatic rv_pkg::word_t alu_reg(input logic [6:0] funct7,
		input logic [2:0] funct3, input int rd, input int rs1, input int rs2);
		return {funct7, 5'(rs2), 5'(rs1), funct3, 5'(rd), 7'b0110011};
	endfunction

	function automatic rv_pkg::word_t addi(input int rd, input int rs1, input int imm);
		rv_pkg::word_t v;
		v = imm;
		return {v[11:0], 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
	endfunction

	function automatic rv_pkg::word_t load_word(input int rd, input int rs1, input int imm);
		rv_pkg::word_t v;
		v = imm;
		return {v[11:0], 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
	endfunction

	function automatic rv_pkg::word_t store_word(input int rs2, input int rs1, input int imm);
		rv_pkg::word_t v;
		v = imm;
		return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'b0100011};
	endfunction

	function automatic rv_pkg::word_t beq(input int rs1, input int rs2, input int imm);
		rv_pkg::word_t v;
		v = imm;
		return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'b000, v[4:1], v[11], 7'b1100011};
	endfunction

	function automatic rv_pkg::word_t jal(input int rd, input int imm);
		rv_pkg::word_t v;
		v = imm;
		return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
	endfunction

	task automatic emit(input rv_pkg::word_t instr);
		imem[load_slot] = instr;
		load_slot = load_slot + 8'd1;
	endtask

	task automatic clear_memories();
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0000_0013;
			dmem[i] = '0;
		end
		load_slot = '0;
		marker_writes = 0;
	endtask

	// store to the done word, then spin on jal x0,0
	task automatic finish_program();
		emit(addi(31, 0, 1));
		emit(store_word(31, 0, int'(done_addr)));
		emit(jal(0, 0));
	endtask

	task automatic run_program();
		done_seen = 1'b0;
		@(posedge clock);
		#1;
		reset = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b1;
		while (!done_seen) begin
			@(posedge clock);
		end
		repeat (4) @(posedge clock);
		@(negedge clock);
		check_flag("data_req", data_req, 1'b0);
		check_flag("req_during_ack", req_during_ack, 1'b0);
	endtask

	task automatic test_reset_state();
		clear_memories();
		@(posedge clock);
		#1;
		reset = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		check_word("instr_addr", instr_addr, 32'h0);
		check_flag("data_req", data_req, 1'b0);
		@(posedge clock);
		#1;
		reset = 1'b1;
		// plain nops, one word per cycle
		repeat (3) @(posedge clock);
		@(negedge clock);
		check_word("instr_addr", instr_addr, 32'd12);
		check_flag("data_req", data_req, 1'b0);
	endtask

	task automatic load_alu_program();
		clear_memories();
		emit(addi(1, 0, alu_a));
		emit(addi(2, 0, alu_b));
		emit(alu_reg(7'h00, 3'b000, 3, 1, 2));
		emit(alu_reg(7'h20, 3'b000, 4, 1, 2));
		emit(alu_reg(7'h00, 3'b111, 5, 1, 2));
		emit(alu_reg(7'h00, 3'b110, 6, 1, 2));
		emit(alu_reg(7'h00, 3'b100, 7, 1, 2));
		emit(alu_reg(7'h00, 3'b010, 8, 2, 1));
		emit(alu_reg(7'h00, 3'b010, 9, 1, 2));
		emit(addi(10, 1, -100));
		for (int r = 3; r <= 10; r++) begin
			emit(store_word(r, 0, alu_base + 4 * (r - 3)));
		end
		finish_program();
	endtask

	task automatic check_alu_results();
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		rv_pkg::word_t expected [8];
		a = alu_a;
		b = alu_b;
		expected[0] = a + b;
		expected[1] = a - b;
		expected[2] = a & b;
		expected[3] = a | b;
		expected[4] = a ^ b;
		expected[5] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
		expected[6] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		expected[7] = a - 32'd100;
		for (int i = 0; i < 8; i++) begin
			check_word($sformatf("mem[%0h]", alu_base + 4 * i),
				read_data(alu_base + 4 * i), expected[i]);
		end
	endtask

	task automatic test_alu_ops();
		backpressure = 1'b0;
		load_alu_program();
		run_program();
		check_alu_results();
	endtask

	task automatic test_dependences();
		rv_pkg::word_t v [7];
		clear_memories();
		emit(addi(1, 0, 5));
		emit(addi(2, 1, 3));
		emit(alu_reg(7'h00, 3'b000, 3, 2, 1));
		emit(alu_reg(7'h20, 3'b000, 4, 3, 1));
		emit(alu_reg(7'h00, 3'b100, 5, 4, 3));
		emit(alu_reg(7'h00, 3'b000, 6, 5, 4));
		for (int r = 2; r <= 6; r++) begin
			emit(store_word(r, 0, chain_base + 4 * (r - 2)));
		end
		finish_program();
		run_program();
		v[1] = 32'd5;
		v[2] = v[1] + 32'd3;
		v[3] = v[2] + v[1];
		v[4] = v[3] - v[1];
		v[5] = v[4] ^ v[3];
		v[6] = v[5] + v[4];
		for (int r = 2; r <= 6; r++) begin
			check_word($sformatf("x%0d stored", r), read_data(chain_base + 4 * (r - 2)), v[r]);
		end
	endtask

	task automatic test_load_use();
		rv_pkg::word_t first;
		rv_pkg::word_t second;
		clear_memories();
		take_bits(32, first);
		take_bits(32, second);
		dmem[load_base >> 2] = first;
		dmem[(load_base + 8) >> 2] = second;
		emit(addi(3, 0, 77));
		emit(load_word(1, 0, load_base));
		emit(alu_reg(7'h00, 3'b000, 2, 1, 3));
		emit(store_word(2, 0, load_base + 4));
		// loaded word used as store data right away
		emit(load_word(4, 0, load_base + 8));
		emit(store_word(4, 0, load_base + 12));
		finish_program();
		run_program();
		check_word("load plus constant", read_data(load_base + 4), first + 32'd77);
		check_word("loaded store data", read_data(load_base + 12), second);
	endtask

	task automatic test_control_flow();
		rv_pkg::word_t jal_pc;
		clear_memories();
		emit(addi(1, 0, 7));
		emit(addi(2, 0, 7));
		emit(addi(3, 0, 9));
		emit(addi(9, 0, int'(marker)));
		emit(beq(1, 2, 12));
		emit(store_word(9, 0, flow_base));
		emit(store_word(9, 0, flow_base + 4));
		emit(beq(1, 3, 12));
		emit(store_word(1, 0, flow_base + 8));
		jal_pc = {22'b0, load_slot, 2'b00};
		emit(jal(5, 12));
		emit(store_word(9, 0, flow_base + 12));
		emit(store_word(9, 0, flow_base + 16));
		emit(store_word(5, 0, flow_base + 20));
		finish_program();
		run_program();
		check_word("taken beq skip 0", read_data(flow_base), 32'h0);
		check_word("taken beq skip 1", read_data(flow_base + 4), 32'h0);
		check_word("not taken beq path", read_data(flow_base + 8), 32'd7);
		check_word("jal skip 0", read_data(flow_base + 12), 32'h0);
		check_word("jal skip 1", read_data(flow_base + 16), 32'h0);
		check_word("link register", read_data(flow_base + 20), jal_pc + 32'd4);
		check_word("marker stores", marker_writes, 32'h0);
	endtask

	task automatic test_backpressure();
		backpressure = 1'b1;
		load_alu_program();
		run_program();
		check_alu_results();
		backpressure = 1'b0;
	endtask

	initial begin
		reset = 1'b0;
		backpressure = 1'b0;
		done_seen = 1'b0;
		errors = 0;
		checks = 0;
		marker_writes = 0;
		load_slot = '0;
		lfsr_state = 32'h2d8a4ffb;
		test_reset_state();
		test_alu_ops();
		test_dependences();
		test_load_use();
		test_control_flow();
		test_backpressure();
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		$finish;
	end

endmodule
